//--- dwc_defs.svh
`ifndef DWC_DEFS_SVH
`define DWC_DEFS_SVH

// lane layout
`define DWC_LANES       4
`define DWC_PIX_W       8
`define DWC_WGT_W       8

// 3x3 window
`define DWC_KERNEL      3
`define DWC_TAPS        9

// buffer sizes
`define DWC_IFM_DEPTH   128
`define DWC_IFM_AW      7
`define DWC_WGT_AW      4

// 9 taps of 255 * 127 fit in 20 signed bits
`define DWC_ACC_W       20
`define DWC_OUT_SHIFT   4

// 64 pixels of 255 fit in 14 bits
`define DWC_POOL_W      14

`endif

//--- dwc_pkg.sv
`include "dwc_defs.svh"

package dwc_pkg;

    // lane i sits in byte i
    typedef logic [`DWC_LANES-1:0][`DWC_PIX_W-1:0] lane_word_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FLUSH
    } gen_state_t;

    // unsigned pixel times signed weight
    typedef logic signed [`DWC_PIX_W+`DWC_WGT_W:0] prod_t;
    typedef logic signed [`DWC_ACC_W-1:0] acc_t;
    typedef logic [`DWC_POOL_W-1:0] pool_sum_t;

    // a frame never holds more pixels than the feature buffer
    typedef logic [`DWC_IFM_AW-1:0] pix_cnt_t;

    // position of the highest set bit, exact for powers of two
    function automatic logic [2:0] log2_pow2(input pix_cnt_t n);
        logic [2:0] r;
        r = '0;
        for (int i = 0; i < $bits(pix_cnt_t); i++) begin
            if (n[i]) begin
                r = 3'(i);
            end
        end
        return r;
    endfunction

endpackage

//--- tap_if.sv
`timescale 1ns/1ps
`include "dwc_defs.svh"

interface tap_if;

    logic [`DWC_IFM_AW-1:0] ifm_addr;
    logic [`DWC_WGT_AW-1:0] wgt_addr;

    // tags, one cycle behind the addresses
    logic                   tap_valid;
    logic                   tap_first;
    logic                   tap_last;
    logic                   frame_last;

    modport gen (
        output ifm_addr, wgt_addr,
        output tap_valid, tap_first, tap_last, frame_last
    );

    modport mem (input ifm_addr, wgt_addr);

    modport pe (input tap_valid, tap_first, tap_last, frame_last);

endinterface

//--- lane_ram.sv
`timescale 1ns/1ps
`include "dwc_defs.svh"

module lane_ram import dwc_pkg::*; #(
    parameter int DEPTH = `DWC_IFM_DEPTH,
    parameter int AW    = `DWC_IFM_AW
) (
    input  logic          clk,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  lane_word_t    wr_data,
    input  logic [AW-1:0] rd_addr,
    output lane_word_t    rd_data
);

    lane_word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // host writes must land inside the buffer
    a_wr_range: assert property (
        @(posedge clk) wr_en |-> (wr_addr < DEPTH)
    );

endmodule

//--- window_addr_gen.sv
`timescale 1ns/1ps
`include "dwc_defs.svh"

module window_addr_gen import dwc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic [3:0] ifm_w,
    output logic       busy,
    tap_if.gen         taps
);

    localparam logic [1:0] K_LAST = 2'(`DWC_KERNEL - 1);

    gen_state_t state;

    logic [3:0] w_q;
    logic [3:0] ow;
    logic [3:0] orow;
    logic [3:0] ocol;
    logic [1:0] ky;
    logic [1:0] kx;
    logic       run;
    logic       first_c;
    logic       last_c;
    logic       frame_c;
    logic [1:0] fl_dly;

    logic [`DWC_IFM_AW-1:0] row_a;
    logic [`DWC_IFM_AW-1:0] col_a;

    // stride 1, no padding
    assign ow  = w_q - 4'd2;
    assign run = (state == RUN);

    assign first_c = (ky == 2'd0) && (kx == 2'd0);
    assign last_c  = (ky == K_LAST) && (kx == K_LAST);
    assign frame_c = last_c && (orow == ow - 4'd1) && (ocol == ow - 4'd1);

    // row * ifm_w + col for the feature buffer, ky * 3 + kx for the weights
    assign row_a = `DWC_IFM_AW'(orow) + `DWC_IFM_AW'(ky);
    assign col_a = `DWC_IFM_AW'(ocol) + `DWC_IFM_AW'(kx);
    assign taps.ifm_addr = row_a * `DWC_IFM_AW'(w_q) + col_a;
    assign taps.wgt_addr = `DWC_WGT_AW'(ky) * `DWC_WGT_AW'(`DWC_KERNEL) + `DWC_WGT_AW'(kx);

    assign busy = (state != IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            w_q   <= '0;
            orow  <= '0;
            ocol  <= '0;
            ky    <= '0;
            kx    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        w_q   <= ifm_w;
                    end
                end
                RUN: begin
                    // kx fastest, then ky, then output column and row
                    if (kx != K_LAST) begin
                        kx <= kx + 2'd1;
                    end else begin
                        kx <= '0;
                        if (ky != K_LAST) begin
                            ky <= ky + 2'd1;
                        end else begin
                            ky <= '0;
                            if (ocol != ow - 4'd1) begin
                                ocol <= ocol + 4'd1;
                            end else begin
                                ocol <= '0;
                                if (orow != ow - 4'd1) begin
                                    orow <= orow + 4'd1;
                                end else begin
                                    orow <= '0;
                                end
                            end
                        end
                    end
                    if (frame_c) begin
                        state <= FLUSH;
                    end
                end
                FLUSH: begin
                    // wait for the product, accumulate and pool stages
                    if (fl_dly[1]) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // tags lag by one cycle to meet the buffer read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taps.tap_valid  <= 1'b0;
            taps.tap_first  <= 1'b0;
            taps.tap_last   <= 1'b0;
            taps.frame_last <= 1'b0;
            fl_dly          <= '0;
        end else begin
            taps.tap_valid  <= run;
            taps.tap_first  <= run && first_c;
            taps.tap_last   <= run && last_c;
            taps.frame_last <= run && frame_c;
            fl_dly          <= {fl_dly[0], taps.frame_last};
        end
    end

    // output pixel count must be a power of two for the pool
    a_ifm_w: assert property (
        @(posedge clk) disable iff (!rst_n)
        (start && state == IDLE) |-> (ifm_w inside {4'd4, 4'd6, 4'd10})
    );

    // busy drops together with the pooled result
    a_busy_end: assert property (
        @(posedge clk) disable iff (!rst_n)
        taps.frame_last |-> ##3 !busy
    );

endmodule

//--- dw_pe_array.sv
`timescale 1ns/1ps
`include "dwc_defs.svh"

module dw_pe_array import dwc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    tap_if.pe          taps,
    input  lane_word_t ifm_data,
    input  lane_word_t wgt_data,
    output logic       ofm_valid,
    output logic       ofm_last,
    output lane_word_t ofm_data
);

    prod_t prod_q [`DWC_LANES];
    acc_t  acc    [`DWC_LANES];
    acc_t  sum    [`DWC_LANES];

    logic valid_q;
    logic first_q;
    logic last_q;
    logic frame_q;

    // clamp at zero, scale down, saturate to a pixel
    function automatic logic [`DWC_PIX_W-1:0] clamp_sat(input acc_t v);
        acc_t s;
        s = v >>> `DWC_OUT_SHIFT;
        if (v < 0) begin
            return '0;
        end else if (s > acc_t'((1 << `DWC_PIX_W) - 1)) begin
            return '1;
        end
        return s[`DWC_PIX_W-1:0];
    endfunction

    // multiply stage
    always_ff @(posedge clk) begin
        if (taps.tap_valid) begin
            for (int i = 0; i < `DWC_LANES; i++) begin
                prod_q[i] <= $signed({1'b0, ifm_data[i]}) * $signed(wgt_data[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
            frame_q <= 1'b0;
        end else begin
            valid_q <= taps.tap_valid;
            first_q <= taps.tap_first;
            last_q  <= taps.tap_last;
            frame_q <= taps.frame_last;
        end
    end

    // first tap restarts the window sum
    always_comb begin
        for (int i = 0; i < `DWC_LANES; i++) begin
            if (first_q) begin
                sum[i] = acc_t'(prod_q[i]);
            end else begin
                sum[i] = acc[i] + acc_t'(prod_q[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            for (int i = 0; i < `DWC_LANES; i++) begin
                acc[i] <= sum[i];
            end
        end
        if (valid_q && last_q) begin
            for (int i = 0; i < `DWC_LANES; i++) begin
                ofm_data[i] <= clamp_sat(sum[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_valid <= 1'b0;
            ofm_last  <= 1'b0;
        end else begin
            ofm_valid <= valid_q && last_q;
            ofm_last  <= valid_q && last_q && frame_q;
        end
    end

    // generator never tags a tap it did not issue
    a_tag_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        (taps.tap_first || taps.tap_last) |-> taps.tap_valid
    );

endmodule

//--- avg_pool.sv
`timescale 1ns/1ps
`include "dwc_defs.svh"

module avg_pool import dwc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ofm_valid,
    input  logic       ofm_last,
    input  lane_word_t ofm_data,
    output logic       pool_valid,
    output lane_word_t pool_data
);

    pool_sum_t sum    [`DWC_LANES];
    pool_sum_t sum_nx [`DWC_LANES];
    pix_cnt_t  cnt;
    pix_cnt_t  total;
    logic [2:0] sh;

    // count including the pixel now arriving
    assign total = cnt + 1'b1;
    assign sh    = log2_pow2(total);

    always_comb begin
        for (int i = 0; i < `DWC_LANES; i++) begin
            sum_nx[i] = sum[i] + pool_sum_t'(ofm_data[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            pool_valid <= 1'b0;
            for (int i = 0; i < `DWC_LANES; i++) begin
                sum[i] <= '0;
            end
        end else begin
            pool_valid <= ofm_valid && ofm_last;
            if (ofm_valid) begin
                // last pixel closes the frame and starts the next from zero
                cnt <= ofm_last ? '0 : total;
                for (int i = 0; i < `DWC_LANES; i++) begin
                    sum[i] <= ofm_last ? '0 : sum_nx[i];
                end
            end
        end
    end

    // divide by the pixel count
    always_ff @(posedge clk) begin
        if (ofm_valid && ofm_last) begin
            for (int i = 0; i < `DWC_LANES; i++) begin
                pool_data[i] <= `DWC_PIX_W'(sum_nx[i] >> sh);
            end
        end
    end

    a_pow2_cnt: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ofm_valid && ofm_last) |-> $onehot(total)
    );

endmodule

//--- dw_conv_top.sv
`timescale 1ns/1ps
`include "dwc_defs.svh"

module dw_conv_top import dwc_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    // host loading
    input  logic                   ifm_wr_en,
    input  logic [`DWC_IFM_AW-1:0] ifm_wr_addr,
    input  lane_word_t             ifm_wr_data,
    input  logic                   wgt_wr_en,
    input  logic [`DWC_WGT_AW-1:0] wgt_wr_addr,
    input  lane_word_t             wgt_wr_data,

    // frame control
    input  logic [3:0]             ifm_w,
    input  logic                   start,
    output logic                   busy,

    output logic                   ofm_valid,
    output lane_word_t             ofm_data,
    output logic                   pool_valid,
    output lane_word_t             pool_data
);

    tap_if u_taps ();

    lane_word_t ifm_data;
    lane_word_t wgt_data;
    logic       ofm_last;

    window_addr_gen u_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .ifm_w (ifm_w),
        .busy  (busy),
        .taps  (u_taps)
    );

    // feature buffer
    lane_ram #(
        .DEPTH (`DWC_IFM_DEPTH),
        .AW    (`DWC_IFM_AW)
    ) u_ifm_ram (
        .clk     (clk),
        .wr_en   (ifm_wr_en),
        .wr_addr (ifm_wr_addr),
        .wr_data (ifm_wr_data),
        .rd_addr (u_taps.ifm_addr),
        .rd_data (ifm_data)
    );

    // weight buffer, one word per tap
    lane_ram #(
        .DEPTH (`DWC_TAPS),
        .AW    (`DWC_WGT_AW)
    ) u_wgt_ram (
        .clk     (clk),
        .wr_en   (wgt_wr_en),
        .wr_addr (wgt_wr_addr),
        .wr_data (wgt_wr_data),
        .rd_addr (u_taps.wgt_addr),
        .rd_data (wgt_data)
    );

    dw_pe_array u_pe (
        .clk       (clk),
        .rst_n     (rst_n),
        .taps      (u_taps),
        .ifm_data  (ifm_data),
        .wgt_data  (wgt_data),
        .ofm_valid (ofm_valid),
        .ofm_last  (ofm_last),
        .ofm_data  (ofm_data)
    );

    avg_pool u_pool (
        .clk        (clk),
        .rst_n      (rst_n),
        .ofm_valid  (ofm_valid),
        .ofm_last   (ofm_last),
        .ofm_data   (ofm_data),
        .pool_valid (pool_valid),
        .pool_data  (pool_data)
    );

endmodule

//--- tb_dw_conv.sv
`timescale 1ns/1ps
`include "dwc_defs.svh"

module tb_dw_conv;

    localparam int N_TESTS  = 5;
    localparam int CYCLE_NS = 10;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   ifm_wr_en;
    logic [`DWC_IFM_AW-1:0] ifm_wr_addr;
    logic [31:0]            ifm_wr_data;
    logic                   wgt_wr_en;
    logic [`DWC_WGT_AW-1:0] wgt_wr_addr;
    logic [31:0]            wgt_wr_data;
    logic [3:0]             ifm_w;
    logic                   start;
    logic                   busy;
    logic                   ofm_valid;
    logic [31:0]            ofm_data;
    logic                   pool_valid;
    logic [31:0]            pool_data;

    // host copy of both buffers with the lane index last
    logic [7:0]        img [`DWC_IFM_DEPTH][4];
    logic signed [7:0] wgt [`DWC_TAPS][4];

    int exp_ofm [64][4];
    int exp_pool [4];
    int n_exp;
    int n_clamp;
    int n_sat;
    int seed = 32'h6008;
    int errors = 0;
    int failed_tests = 0;

    dw_conv_top u_dut (.*);

    always #(CYCLE_NS / 2) clk = ~clk;

    initial begin
        #((16 + N_TESTS * 1000) * CYCLE_NS);
        $display("error: watchdog expired, the run did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic random_pixels();
        for (int a = 0; a < `DWC_IFM_DEPTH; a++) begin
            for (int l = 0; l < 4; l++) begin
                img[a][l] = 8'(rand_range(0, 255));
            end
        end
    endtask

    task automatic random_weights(input int lane, input int lo, input int hi);
        for (int t = 0; t < `DWC_TAPS; t++) begin
            wgt[t][lane] = 8'(rand_range(lo, hi));
        end
    endtask

    // one word per cycle with the weights riding along on the first nine pixels
    task automatic load_buffers(input int w);
        for (int a = 0; a < w * w; a++) begin
            @(posedge clk);
            #1;
            ifm_wr_en   = 1'b1;
            ifm_wr_addr = `DWC_IFM_AW'(a);
            ifm_wr_data = {img[a][3], img[a][2], img[a][1], img[a][0]};
            wgt_wr_en   = (a < `DWC_TAPS);
            if (a < `DWC_TAPS) begin
                wgt_wr_addr = `DWC_WGT_AW'(a);
                wgt_wr_data = {wgt[a][3], wgt[a][2], wgt[a][1], wgt[a][0]};
            end
        end
        @(posedge clk);
        #1;
        ifm_wr_en = 1'b0;
        wgt_wr_en = 1'b0;
    endtask

    // reference model of a 3x3 window at stride 1 without padding in raster order
    task automatic build_expected(input int w);
        int ow;
        int s;
        int r;
        int pv;
        int wv;
        int tot [4];
        ow      = w - 2;
        n_exp   = ow * ow;
        n_clamp = 0;
        n_sat   = 0;
        for (int l = 0; l < 4; l++) begin
            tot[l] = 0;
        end
        for (int p = 0; p < n_exp; p++) begin
            for (int l = 0; l < 4; l++) begin
                s = 0;
                for (int t = 0; t < `DWC_TAPS; t++) begin
                    pv = img[(p / ow + t / 3) * w + p % ow + t % 3][l];
                    wv = wgt[t][l];
                    s += pv * wv;
                end
                if (s < 0) begin
                    r = 0;
                    n_clamp++;
                end else begin
                    r = s >>> `DWC_OUT_SHIFT;
                    if (r > 255) begin
                        r = 255;
                        n_sat++;
                    end
                end
                exp_ofm[p][l] = r;
                tot[l] += r;
            end
        end
        // the pixel count is a power of two so this equals the shift
        for (int l = 0; l < 4; l++) begin
            exp_pool[l] = tot[l] / n_exp;
        end
    endtask

    // extra_at > 0 puts a second start on the bus that many cycles in
    task automatic run_frame(input int w, input int extra_at);
        int  n_got;
        int  last_i;
        int  limit;
        bit  done;
        build_expected(w);
        n_got  = 0;
        last_i = 0;
        done   = 1'b0;
        limit  = 9 * n_exp + 40;
        @(posedge clk);
        #1;
        ifm_w = 4'(w);
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        if (!busy) begin
            errors++;
            $display("error: busy did not rise after start at time %0t", $time);
        end
        for (int i = 1; i <= limit && !done; i++) begin
            @(posedge clk);
            #1;
            start = (i == extra_at);
            ifm_w = (i == extra_at) ? 4'd10 : 4'(w);
            @(negedge clk);
            if (ofm_valid) begin
                if (n_got >= n_exp) begin
                    errors++;
                    $display("error: output pixel beyond the %0d of the frame", n_exp);
                end else begin
                    if (i != 9 * n_got + 11) begin
                        errors++;
                        $display(
                            "mismatch at time %0t: pixel %0d at cycle %0d, expected %0d",
                            $time, n_got, i, 9 * n_got + 11);
                    end
                    for (int l = 0; l < 4; l++) begin
                        if (ofm_data[8*l +: 8] != exp_ofm[n_got][l]) begin
                            errors++;
                            $display(
                                "mismatch at time %0t: pixel %0d lane %0d got %0d expected %0d",
                                $time, n_got, l, ofm_data[8*l +: 8], exp_ofm[n_got][l]);
                        end
                    end
                end
                n_got++;
                last_i = i;
            end
            if (pool_valid) begin
                done = 1'b1;
                if (n_got != n_exp) begin
                    errors++;
                    $display("error: frame closed after %0d of %0d pixels", n_got, n_exp);
                end
                if (i != last_i + 1) begin
                    errors++;
                    $display("mismatch at time %0t: pooled result %0d cycles after the last pixel",
                             $time, i - last_i);
                end
                if (busy) begin
                    errors++;
                    $display("error: busy still high with the pooled result at time %0t",
                             $time);
                end
                for (int l = 0; l < 4; l++) begin
                    if (pool_data[8*l +: 8] != exp_pool[l]) begin
                        errors++;
                        $display("mismatch at time %0t: pool lane %0d got %0d expected %0d",
                                 $time, l, pool_data[8*l +: 8], exp_pool[l]);
                    end
                end
            end else if (!busy) begin
                done = 1'b1;
                errors++;
                $display("error: busy fell before the pooled result at time %0t", $time);
            end
        end
        if (!done) begin
            errors++;
            $display("error: no pooled result within %0d cycles of start", limit);
        end
    endtask

    task automatic check_idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (busy || ofm_valid || pool_valid) begin
                errors++;
                $display("error: activity on the outputs while idle at time %0t", $time);
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_reset_and_start();
        int e0;
        e0 = errors;
        check_idle(20);
        random_pixels();
        for (int l = 0; l < 4; l++) begin
            random_weights(l, -20, 20);
        end
        load_buffers(4);
        run_frame(4, 0);
        report_test("reset and start", e0);
    endtask

    // only the centre tap at 16 passes the centre pixel through
    task automatic test_centre_weight();
        int e0;
        e0 = errors;
        for (int a = 0; a < `DWC_IFM_DEPTH; a++) begin
            for (int l = 0; l < 4; l++) begin
                img[a][l] = 8'(a * 29 + l * 64 + 7);
            end
        end
        for (int t = 0; t < `DWC_TAPS; t++) begin
            for (int l = 0; l < 4; l++) begin
                wgt[t][l] = (t == 4) ? 8'sd16 : 8'sd0;
            end
        end
        load_buffers(4);
        run_frame(4, 0);
        report_test("centre weight", e0);
    endtask

    task automatic test_random_6();
        int e0;
        e0 = errors;
        random_pixels();
        random_weights(0, -128, 127);
        // lane 1 is always negative and lane 2 large enough to saturate
        random_weights(1, -128, -1);
        random_weights(2, 64, 127);
        random_weights(3, -30, 30);
        load_buffers(6);
        run_frame(6, 0);
        if (n_clamp == 0 || n_sat == 0) begin
            errors++;
            $display("error: stimulus gave no clamped or no saturated output");
        end
        report_test("random width 6", e0);
    endtask

    task automatic test_random_10();
        int e0;
        e0 = errors;
        random_pixels();
        for (int l = 0; l < 4; l++) begin
            random_weights(l, -24, 24);
        end
        load_buffers(10);
        run_frame(10, 0);
        report_test("random width 10", e0);
    endtask

    // second frame reads the same buffer at width 4
    task automatic test_busy_start();
        int e0;
        e0 = errors;
        random_pixels();
        for (int l = 0; l < 4; l++) begin
            random_weights(l, -40, 40);
        end
        load_buffers(6);
        run_frame(6, 30);
        run_frame(4, 0);
        check_idle(30);
        report_test("start while busy", e0);
    endtask

    initial begin
        rst_n       = 1'b0;
        ifm_wr_en   = 1'b0;
        ifm_wr_addr = '0;
        ifm_wr_data = '0;
        wgt_wr_en   = 1'b0;
        wgt_wr_addr = '0;
        wgt_wr_data = '0;
        ifm_w       = 4'd4;
        start       = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_and_start();
        test_centre_weight();
        test_random_6();
        test_random_10();
        test_busy_start();
        $display("tests run: %0d, failed tests: %0d, errors: %0d",
                 N_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
dwc_pkg.sv
tap_if.sv
lane_ram.sv
window_addr_gen.sv
dw_pe_array.sv
avg_pool.sv
dw_conv_top.sv
tb_dw_conv.sv

//--- Makefile
SIM := obj_dir/Vtb_dw_conv

all: run

$(SIM): verilog.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_dw_conv

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
